//--- hdl/mem_stage_pkg.sv
package mem_stage_pkg;

    typedef logic [31:0] word_t;

    // Access width (stores only use LB, LH and LW)
    typedef enum logic [2:0] {
        LT_NONE,
        LB,
        LH,
        LW,
        LBU,
        LHU
    } load_type_e;

    // Writeback source
    typedef enum logic [1:0] {
        W_SEL_ALU,
        W_SEL_DLOAD,
        W_SEL_PC4,
        W_SEL_IMM_U
    } w_sel_e;

    // One operation handed over by execute
    typedef struct packed {
        logic       dren;
        logic       dwen;
        logic       ifence;
        logic       sfence;
        load_type_e load_type;
        word_t      port_out;
        word_t      rs2_data;
        word_t      pc4;
        word_t      imm_u;
        logic [4:0] rd;
        logic       reg_write;
        w_sel_e     w_sel;
    } ex_mem_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        logic [3:0] byte_en;
        word_t      wdata;
    } dbus_req_t;

    typedef struct packed {
        logic  busy;
        logic  error;
        word_t rdata;
    } dbus_rsp_t;

    // Bit order matches maint_rsp_t channel by channel
    typedef struct packed {
        logic icache_flush;
        logic dcache_flush;
        logic itlb_fence;
        logic dtlb_fence;
    } maint_req_t;

    typedef struct packed {
        logic iflush_done;
        logic dflush_done;
        logic itlb_done;
        logic dtlb_done;
    } maint_rsp_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       reg_write;
        word_t      wdata;
        logic       mal_l;
        logic       mal_s;
        logic       fault_l;
        logic       fault_s;
    } wb_t;

endpackage

//--- hdl/load_extender.sv
`timescale 1ns/1ps

module load_extender import mem_stage_pkg::*; (
    input  word_t      rdata,
    input  load_type_e load_type,
    input  logic [1:0] byte_offset,
    output word_t      ext_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Little-endian lane pick
    assign sel_byte = rdata[8*byte_offset +: 8];
    assign sel_half = byte_offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (load_type)
            LB:      ext_out = {{24{sel_byte[7]}}, sel_byte};
            LBU:     ext_out = {24'h0, sel_byte};
            LH:      ext_out = {{16{sel_half[15]}}, sel_half};
            LHU:     ext_out = {16'h0, sel_half};
            LW:      ext_out = rdata;
            default: ext_out = '0;
        endcase
    end

endmodule

//--- hdl/fence_tracker.sv
`timescale 1ns/1ps

module fence_tracker #(
    parameter bit BYPASS = 1'b0
) (
    input  logic CLK,
    input  logic nRST,
    input  logic active,
    input  logic done_a,
    input  logic done_b,
    output logic pulse,
    output logic stall
);

    logic issued;
    logic seen_a;
    logic seen_b;
    logic both_seen;

    // One pulse on the first cycle the fence is held
    assign pulse     = active && !issued && !BYPASS;
    assign both_seen = seen_a && seen_b;
    assign stall     = pulse || (issued && !both_seen);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issued <= 1'b0;
            seen_a <= 1'b1;
            seen_b <= 1'b1;
        end else begin
            if (pulse) begin
                issued <= 1'b1;
            end else if (both_seen) begin
                // Fence leaves this cycle so rearm for the next one
                issued <= 1'b0;
            end

            // A done in the pulse cycle still counts
            if (done_a) begin
                seen_a <= 1'b1;
            end else if (pulse) begin
                seen_a <= 1'b0;
            end

            if (done_b) begin
                seen_b <= 1'b1;
            end else if (pulse) begin
                seen_b <= 1'b0;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        pulse |=> !pulse);

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mem_stage_pkg::*; #(
    parameter int TRANSLATION_ON = 1
) (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       in_valid,
    output logic       in_ready,
    input  ex_mem_t    in_op,
    output dbus_req_t  dbus_req,
    input  dbus_rsp_t  dbus_rsp,
    output maint_req_t maint_req,
    input  maint_rsp_t maint_rsp,
    output logic       wb_valid,
    output wb_t        wb
);

    ex_mem_t    op;
    logic       held;
    logic [1:0] byte_offset;
    logic       mal_addr;
    logic       bus_on;
    logic       mem_done;
    logic       cache_pulse;
    logic       cache_stall;
    logic       tlb_pulse;
    logic       tlb_stall;
    logic       leave;
    logic [3:0] byte_en;
    word_t      store_data;
    word_t      load_ext;

    // Valid tag of the ex/mem register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held <= 1'b0;
        end else if (in_valid && in_ready) begin
            held <= 1'b1;
        end else if (leave) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid && in_ready) begin
            op <= in_op;
        end
    end

    // Operation leaves when the bus and both fence pairs are done
    assign leave    = held && mem_done && !cache_stall && !tlb_stall;
    assign in_ready = !held || leave;
    assign wb_valid = leave;

    assign byte_offset = op.port_out[1:0];

    always_comb begin
        case (op.load_type)
            LH, LHU: mal_addr = byte_offset[0];
            LW:      mal_addr = byte_offset != 2'b00;
            default: mal_addr = 1'b0;
        endcase
    end

    always_comb begin
        case (op.load_type)
            LB, LBU: byte_en = 4'b0001 << byte_offset;
            LH, LHU: byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
            LW:      byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    // Replicate the store value so every lane carries it
    always_comb begin
        case (op.load_type)
            LB:      store_data = {4{op.rs2_data[7:0]}};
            LH:      store_data = {2{op.rs2_data[15:0]}};
            LW:      store_data = op.rs2_data;
            default: store_data = '0;
        endcase
    end

    // Misaligned accesses never reach the bus
    assign bus_on   = held && (op.dren || op.dwen) && !mal_addr;
    assign mem_done = !bus_on || !dbus_rsp.busy;

    assign dbus_req.ren     = bus_on && op.dren;
    assign dbus_req.wen     = bus_on && op.dwen;
    assign dbus_req.addr    = op.port_out;
    assign dbus_req.byte_en = byte_en;
    assign dbus_req.wdata   = store_data;

    load_extender load_ext_u (
        .rdata       (dbus_rsp.rdata),
        .load_type   (op.load_type),
        .byte_offset (byte_offset),
        .ext_out     (load_ext)
    );

    fence_tracker #(
        .BYPASS (1'b0)
    ) cache_fence (
        .CLK    (CLK),
        .nRST   (nRST),
        .active (held && op.ifence),
        .done_a (maint_rsp.iflush_done),
        .done_b (maint_rsp.dflush_done),
        .pulse  (cache_pulse),
        .stall  (cache_stall)
    );

    // Without translation the TLB pair counts as done at once
    fence_tracker #(
        .BYPASS (TRANSLATION_ON == 0)
    ) tlb_fence (
        .CLK    (CLK),
        .nRST   (nRST),
        .active (held && op.sfence),
        .done_a (maint_rsp.itlb_done),
        .done_b (maint_rsp.dtlb_done),
        .pulse  (tlb_pulse),
        .stall  (tlb_stall)
    );

    assign maint_req.icache_flush = cache_pulse;
    assign maint_req.dcache_flush = cache_pulse;
    assign maint_req.itlb_fence   = tlb_pulse;
    assign maint_req.dtlb_fence   = tlb_pulse;

    always_comb begin
        wb.rd        = op.rd;
        wb.reg_write = op.reg_write && !((op.dren || op.dwen) && mal_addr);
        wb.mal_l     = op.dren && mal_addr;
        wb.mal_s     = op.dwen && mal_addr;
        wb.fault_l   = op.dren && bus_on && dbus_rsp.error;
        wb.fault_s   = op.dwen && bus_on && dbus_rsp.error;
        case (op.w_sel)
            W_SEL_DLOAD: wb.wdata = load_ext;
            W_SEL_PC4:   wb.wdata = op.pc4;
            W_SEL_IMM_U: wb.wdata = op.imm_u;
            default:     wb.wdata = op.port_out;
        endcase
    end

    // Load and store are exclusive within one operation
    assert property (@(posedge CLK) disable iff (!nRST)
        held |-> !(op.dren && op.dwen));

    // A writeback needs an op taken on the last edge or kept from before
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_valid |-> $past(in_valid && in_ready) || $past(held && !leave));

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram import mem_stage_pkg::*; #(
    parameter int RAM_WORDS   = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic      CLK,
    input  logic      nRST,
    input  dbus_req_t req,
    output dbus_rsp_t rsp
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int CW = $clog2(RAM_LATENCY + 2);

    logic [3:0][7:0] mem [RAM_WORDS];
    logic [CW-1:0]   wait_cnt;
    logic            req_on;
    logic            in_range;
    logic            complete;
    logic [AW-1:0]   index;

    assign req_on   = req.ren || req.wen;
    assign in_range = req.addr < 32'(4 * RAM_WORDS);
    assign index    = req.addr[AW+1:2];

    // Busy from the first cycle of a request for RAM_LATENCY cycles
    assign rsp.busy  = req_on && (wait_cnt < CW'(RAM_LATENCY));
    assign complete  = req_on && !rsp.busy;
    assign rsp.error = req_on && !in_range;
    assign rsp.rdata = (req_on && in_range) ? mem[index] : '0;

    // Cleared on completion so a back-to-back request restarts at zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (rsp.busy) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (complete && req.wen && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b]) begin
                    mem[index][b] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- hdl/maint_engine.sv
`timescale 1ns/1ps

module maint_engine import mem_stage_pkg::*; #(
    parameter int MAINT_CYCLES = 5
) (
    input  logic       CLK,
    input  logic       nRST,
    input  maint_req_t req,
    output maint_rsp_t rsp
);

    localparam int CW = $clog2(MAINT_CYCLES + 1);

    logic [3:0] start;
    logic [3:0] done;

    // Request and done bits share positions
    assign start = req;
    assign rsp   = maint_rsp_t'(done);

    for (genvar ch = 0; ch < 4; ch++) begin : g_chan
        logic [CW-1:0] count;
        logic          running;

        // Done lands MAINT_CYCLES cycles after the pulse
        assign done[ch] = running && (count == '0);

        always_ff @(posedge CLK, negedge nRST) begin
            if (!nRST) begin
                running <= 1'b0;
                count   <= '0;
            end else if (start[ch]) begin
                running <= 1'b1;
                count   <= CW'(MAINT_CYCLES - 1);
            end else if (done[ch]) begin
                running <= 1'b0;
            end else if (running) begin
                count <= count - 1'b1;
            end
        end

        assert property (@(posedge CLK) disable iff (!nRST)
            start[ch] |-> !running || done[ch]);
    end

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top import mem_stage_pkg::*; #(
    parameter int RAM_WORDS      = 256,
    parameter int RAM_LATENCY    = 2,
    parameter int MAINT_CYCLES   = 5,
    parameter int TRANSLATION_ON = 1
) (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    in_valid,
    output logic    in_ready,
    input  ex_mem_t in_op,
    output logic    wb_valid,
    output wb_t     wb
);

    dbus_req_t  dbus_req;
    dbus_rsp_t  dbus_rsp;
    maint_req_t maint_req;
    maint_rsp_t maint_rsp;

    mem_stage #(
        .TRANSLATION_ON (TRANSLATION_ON)
    ) stage_u (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_op     (in_op),
        .dbus_req  (dbus_req),
        .dbus_rsp  (dbus_rsp),
        .maint_req (maint_req),
        .maint_rsp (maint_rsp),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    data_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) ram_u (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (dbus_req),
        .rsp  (dbus_rsp)
    );

    // Stands in for the caches and TLBs
    maint_engine #(
        .MAINT_CYCLES (MAINT_CYCLES)
    ) maint_u (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (maint_req),
        .rsp  (maint_rsp)
    );

endmodule

//--- verif/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int RAM_LATENCY  = 2;
    localparam int MAINT_CYCLES = 5;
    localparam int MAX_GAP      = 3;
    localparam int RAND_COUNT   = 200;
    localparam int MEM_LAT      = RAM_LATENCY + 1;
    localparam int FENCE_LAT    = MAINT_CYCLES + 2;

    typedef struct {
        ex_mem_t op;
        int      gap;
        wb_t     exp;
        int      lat;
    } entry_t;

    logic    CLK;
    logic    nRST;
    logic    in_valid;
    logic    in_ready;
    ex_mem_t in_op;
    logic    wb_valid;
    wb_t     wb;

    entry_t     table_q[$];
    wb_t        exp_q[$];
    int         lat_q[$];
    int         acc_q[$];
    logic [7:0] ref_mem [0:1023];
    int         cyc;
    int         limit;
    int         value_errs;
    int         proto_errs;

    mem_subsys_top uut (
        .CLK      (CLK),
        .nRST     (nRST),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    function automatic ex_mem_t store_op(load_type_e lt, word_t addr, word_t data);
        ex_mem_t op;
        op           = '0;
        op.dwen      = 1'b1;
        op.load_type = lt;
        op.port_out  = addr;
        op.rs2_data  = data;
        op.w_sel     = W_SEL_ALU;
        return op;
    endfunction

    function automatic ex_mem_t load_op(load_type_e lt, word_t addr, logic [4:0] rd);
        ex_mem_t op;
        op           = '0;
        op.dren      = 1'b1;
        op.load_type = lt;
        op.port_out  = addr;
        op.rd        = rd;
        op.reg_write = 1'b1;
        op.w_sel     = W_SEL_DLOAD;
        return op;
    endfunction

    function automatic ex_mem_t plain_op(w_sel_e sel, word_t alu, word_t pc4, word_t immu,
                                         logic [4:0] rd);
        ex_mem_t op;
        op           = '0;
        op.port_out  = alu;
        op.pc4       = pc4;
        op.imm_u     = immu;
        op.rd        = rd;
        op.reg_write = 1'b1;
        op.w_sel     = sel;
        return op;
    endfunction

    function automatic ex_mem_t fence_op(bit sfence);
        ex_mem_t op;
        op        = '0;
        op.ifence = !sfence;
        op.sfence = sfence;
        op.w_sel  = W_SEL_ALU;
        return op;
    endfunction

    function automatic wb_t make_wb(logic [4:0] rd, logic rw, word_t data,
                                    logic ml, logic ms, logic fl, logic fs);
        wb_t w;
        w.rd        = rd;
        w.reg_write = rw;
        w.wdata     = data;
        w.mal_l     = ml;
        w.mal_s     = ms;
        w.fault_l   = fl;
        w.fault_s   = fs;
        return w;
    endfunction

    task automatic add_entry(ex_mem_t op, int gap, wb_t exp, int lat);
        entry_t e;
        e.op  = op;
        e.gap = gap;
        e.exp = exp;
        e.lat = lat;
        table_q.push_back(e);
    endtask

    // Little-endian read of the reference memory with RV32I extension
    function automatic word_t ref_load(load_type_e lt, word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[addr[9:0]];
        h = {ref_mem[addr[9:0] + 10'd1], b};
        case (lt)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return {ref_mem[addr[9:0] + 10'd3], ref_mem[addr[9:0] + 10'd2], h};
        endcase
    endfunction

    task automatic ref_store(load_type_e lt, word_t addr, word_t data);
        int n;
        n = (lt == LB) ? 1 : (lt == LH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[addr[9:0] + 10'(i)] = data[8*i +: 8];
        end
    endtask

    task automatic build_table();
        // Stores of each width
        add_entry(store_op(LW, 32'h10, 32'h8899aabb), 0, make_wb(0, 0, 32'h10, 0, 0, 0, 0), MEM_LAT);
        add_entry(store_op(LB, 32'h21, 32'h000000f5), 1, make_wb(0, 0, 32'h21, 0, 0, 0, 0), MEM_LAT);
        add_entry(store_op(LH, 32'h26, 32'h00001234), 0, make_wb(0, 0, 32'h26, 0, 0, 0, 0), MEM_LAT);
        add_entry(store_op(LB, 32'h23, 32'h0000007e), 2, make_wb(0, 0, 32'h23, 0, 0, 0, 0), MEM_LAT);
        // Loads at every legal offset
        add_entry(load_op(LW, 32'h10, 1), 0, make_wb(1, 1, 32'h8899aabb, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LB, 32'h10, 2), 0, make_wb(2, 1, 32'hffffffbb, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LB, 32'h11, 3), 1, make_wb(3, 1, 32'hffffffaa, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LBU, 32'h12, 4), 0, make_wb(4, 1, 32'h00000099, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LB, 32'h13, 5), 0, make_wb(5, 1, 32'hffffff88, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LH, 32'h10, 6), 3, make_wb(6, 1, 32'hffffaabb, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LHU, 32'h12, 7), 0, make_wb(7, 1, 32'h00008899, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LH, 32'h12, 8), 0, make_wb(8, 1, 32'hffff8899, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LW, 32'h20, 9), 0, make_wb(9, 1, 32'h7e00f500, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LBU, 32'h21, 10), 1, make_wb(10, 1, 32'h000000f5, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LB, 32'h23, 11), 0, make_wb(11, 1, 32'h0000007e, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LH, 32'h26, 12), 0, make_wb(12, 1, 32'h00001234, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LHU, 32'h24, 13), 0, make_wb(13, 1, 32'h00000000, 0, 0, 0, 0), MEM_LAT);
        // Misaligned accesses never touch the bus
        add_entry(load_op(LH, 32'h11, 14), 0, make_wb(14, 0, 32'h0, 1, 0, 0, 0), 1);
        add_entry(store_op(LW, 32'h12, 32'hffffffff), 0, make_wb(0, 0, 32'h12, 0, 1, 0, 0), 1);
        add_entry(store_op(LH, 32'h13, 32'hffffffff), 2, make_wb(0, 0, 32'h13, 0, 1, 0, 0), 1);
        add_entry(load_op(LW, 32'h22, 15), 0, make_wb(15, 0, 32'h0, 1, 0, 0, 0), 1);
        add_entry(load_op(LW, 32'h10, 16), 0, make_wb(16, 1, 32'h8899aabb, 0, 0, 0, 0), MEM_LAT);
        add_entry(load_op(LW, 32'h20, 17), 0, make_wb(17, 1, 32'h7e00f500, 0, 0, 0, 0), MEM_LAT);
        // Out of range
        add_entry(store_op(LW, 32'h400, 32'hdeadbeef), 0, make_wb(0, 0, 32'h400, 0, 0, 0, 1), MEM_LAT);
        add_entry(load_op(LW, 32'h7fc, 18), 1, make_wb(18, 1, 32'h0, 0, 0, 1, 0), MEM_LAT);
        add_entry(load_op(LW, 32'h0, 19), 0, make_wb(19, 1, 32'h0, 0, 0, 0, 0), MEM_LAT);
        // Writeback select on plain operations
        add_entry(plain_op(W_SEL_ALU, 32'h1357, 32'h104, 32'habcde000, 20), 0,
                  make_wb(20, 1, 32'h1357, 0, 0, 0, 0), 1);
        add_entry(plain_op(W_SEL_PC4, 32'h1357, 32'h104, 32'habcde000, 21), 0,
                  make_wb(21, 1, 32'h104, 0, 0, 0, 0), 1);
        add_entry(plain_op(W_SEL_IMM_U, 32'h1357, 32'h104, 32'habcde000, 22), 2,
                  make_wb(22, 1, 32'habcde000, 0, 0, 0, 0), 1);
        // Fences followed directly by a normal operation
        add_entry(fence_op(0), 0, make_wb(0, 0, 32'h0, 0, 0, 0, 0), FENCE_LAT);
        add_entry(fence_op(1), 0, make_wb(0, 0, 32'h0, 0, 0, 0, 0), FENCE_LAT);
        add_entry(plain_op(W_SEL_ALU, 32'h2468, 32'h0, 32'h0, 23), 0,
                  make_wb(23, 1, 32'h2468, 0, 0, 0, 0), 1);
    endtask

    task automatic send(ex_mem_t op, int gap, wb_t exp, int lat);
        for (int i = 0; i < gap; i++) begin
            in_valid = 1'b0;
            @(posedge CLK);
            #0.5;
        end
        in_valid = 1'b1;
        in_op    = op;
        while (!in_ready) begin
            @(posedge CLK);
            #0.5;
        end
        exp_q.push_back(exp);
        lat_q.push_back(lat);
        acc_q.push_back(cyc);
        @(posedge CLK);
        #0.5;
        in_valid = 1'b0;
        if ((op.ifence || op.sfence) && in_ready) begin
            proto_errs++;
            $display("in_ready stayed high while a fence was held at %0t", $time);
        end
    endtask

    // Results come back in order, one per accepted operation
    always @(negedge CLK) begin
        wb_t exp;
        int  lat;
        int  acc;
        if (nRST && wb_valid) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("writeback at %0t with no operation outstanding", $time);
            end else begin
                exp = exp_q.pop_front();
                lat = lat_q.pop_front();
                acc = acc_q.pop_front();
                if (wb.rd !== exp.rd) begin
                    value_errs++;
                    $display("ERR %0t: rd %0d, expected %0d", $time, wb.rd, exp.rd);
                end
                if (wb.reg_write !== exp.reg_write) begin
                    value_errs++;
                    $display("ERR %0t: reg_write %b, expected %b", $time, wb.reg_write,
                             exp.reg_write);
                end
                if (wb.wdata !== exp.wdata) begin
                    value_errs++;
                    $display("ERR %0t: wdata %h, expected %h", $time, wb.wdata, exp.wdata);
                end
                if ({wb.mal_l, wb.mal_s, wb.fault_l, wb.fault_s} !==
                    {exp.mal_l, exp.mal_s, exp.fault_l, exp.fault_s}) begin
                    value_errs++;
                    $display("ERR %0t: mal_l/mal_s/fault_l/fault_s %b%b%b%b, expected %b%b%b%b",
                             $time, wb.mal_l, wb.mal_s, wb.fault_l, wb.fault_s,
                             exp.mal_l, exp.mal_s, exp.fault_l, exp.fault_s);
                end
                if (cyc - acc != lat) begin
                    value_errs++;
                    $display("ERR %0t: latency %0d, expected %0d", $time, cyc - acc, lat);
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (limit > 0 && cyc > limit) begin
            $display("timeout after %0d cycles with %0d results outstanding", cyc, exp_q.size());
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        load_type_e lt;
        word_t      addr;
        word_t      data;
        logic [4:0] rd;
        int         kind;
        CLK        = 1'b0;
        nRST       = 1'b0;
        in_valid   = 1'b0;
        in_op      = '0;
        cyc        = 0;
        limit      = 0;
        value_errs = 0;
        proto_errs = 0;
        void'($urandom(32'h0c53f4a9));
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;
        end
        build_table();
        limit = (table_q.size() + RAND_COUNT) * (RAM_LATENCY + MAINT_CYCLES + MAX_GAP + 4) + 100;
        repeat (16) @(posedge CLK);
        #0.5;
        nRST = 1'b1;

        foreach (table_q[i]) begin
            send(table_q[i].op, table_q[i].gap, table_q[i].exp, table_q[i].lat);
        end

        // Random aligned traffic in 0x200..0x3ff away from the table's addresses
        for (int i = 0; i < RAND_COUNT; i++) begin
            kind = int'($urandom_range(9, 0));
            data = $urandom;
            rd   = 5'($urandom_range(31, 1));
            case (kind % 5)
                0:       lt = LB;
                1:       lt = LBU;
                2:       lt = LH;
                3:       lt = LHU;
                default: lt = LW;
            endcase
            addr = 32'h200 + 32'($urandom_range(511, 0));
            if (lt == LH || lt == LHU) begin
                addr[0] = 1'b0;
            end else if (lt == LW) begin
                addr[1:0] = 2'b00;
            end
            if (kind >= 5) begin
                lt = (lt == LBU) ? LB : (lt == LHU) ? LH : lt;
                ref_store(lt, addr, data);
                send(store_op(lt, addr, data), int'($urandom_range(MAX_GAP, 0)),
                     make_wb(0, 0, addr, 0, 0, 0, 0), MEM_LAT);
            end else begin
                send(load_op(lt, addr, rd), int'($urandom_range(MAX_GAP, 0)),
                     make_wb(rd, 1, ref_load(lt, addr), 0, 0, 0, 0), MEM_LAT);
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge CLK);
        end
        repeat (10) @(posedge CLK);

        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/mem_stage_pkg.sv
hdl/load_extender.sv
hdl/fence_tracker.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/maint_engine.sv
hdl/mem_subsys_top.sv
verif/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
